//--- source/linPkg.sv
package linPkg;

  // Buffer depths and host credit counters
  localparam int CmdFifoDepth = 4;
  localparam int RxFifoDepth = 4;
  localparam int CreditWidth = 3;

  // LIN frame layout
  localparam int BreakBits = 13;
  localparam int FrameBits = 9;
  localparam logic [7:0] SyncByte = 8'h55;

  // Clocks per eight bit times, low three bits are the fraction
  typedef logic [15:0] baud_t;

  // Clocks in one bit
  typedef logic [12:0] bitLen_t;

  // Bits left in a symbol
  typedef logic [3:0] bitCnt_t;

  // Line pattern, LSB goes out first
  typedef logic [15:0] symbol_t;

  // Bit 8 set marks a header with the identifier in bits 5..0
  typedef logic [8:0] cmdWord_t;

  // Bit 8 flags a low stop bit, bits 7..0 hold the data
  typedef logic [8:0] rxWord_t;

endpackage

//--- source/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
  parameter type payload_t = logic [8:0],
  parameter int depth = 4
) (
  input logic clkH,
  input logic rst,
  input logic push,
  input payload_t pushData,
  input logic pop,
  output payload_t head,
  output logic notEmpty,
  output logic notFull
);

  typedef logic [$clog2(depth)-1:0] ptr_t;
  typedef logic [$clog2(depth):0] count_t;

  payload_t mem [depth];
  ptr_t rdPtr;
  ptr_t wrPtr;
  count_t count;
  logic doPush;
  logic doPop;

  // Push into a full buffer is dropped, pop from an empty one is ignored
  assign doPush = push && notFull;
  assign doPop = pop && notEmpty;

  assign notEmpty = (count != '0);
  assign notFull = (count != count_t'(depth));
  assign head = mem[rdPtr];

  always_ff @(posedge clkH) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clkH) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == ptr_t'(depth - 1)) ? '0 : wrPtr + ptr_t'(1);
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptr_t'(depth - 1)) ? '0 : rdPtr + ptr_t'(1);
      end
      // Push and pop together leave the count alone
      if (doPush && !doPop) begin
        count <= count + count_t'(1);
      end else if (doPop && !doPush) begin
        count <= count - count_t'(1);
      end
    end
  end

endmodule

//--- source/bitTimer.sv
`timescale 1ns/1ps

module bitTimer #(
  parameter bit halfLastBit = 1'b0
) (
  input logic clkH,
  input logic rst,
  input linPkg::baud_t baud,
  input logic start,
  input linPkg::bitCnt_t bitCount,
  input logic cancel,
  output logic nextBit,
  output linPkg::bitCnt_t bitsLeft,
  output logic busy
);

  import linPkg::*;

  logic [7:0] pattern;
  logic [7:0] longShort;
  bitLen_t lenCount;
  bitLen_t corrLen;
  bitCnt_t bitCnt;
  bitCnt_t cntNext;
  logic step;

  // One long bit per step of the fraction, spread over eight bits
  always_comb begin
    case (baud[2:0])
      3'd0: pattern = 8'b00000000;
      3'd1: pattern = 8'b10000000;
      3'd2: pattern = 8'b10001000;
      3'd3: pattern = 8'b10100100;
      3'd4: pattern = 8'b10101010;
      3'd5: pattern = 8'b10110110;
      3'd6: pattern = 8'b11101110;
      default: pattern = 8'b11101111;
    endcase
  end

  assign nextBit = (lenCount == '0) && (bitCnt != '0);
  assign busy = (lenCount != '0) || (bitCnt != '0);
  assign bitsLeft = bitCnt;
  assign step = start || nextBit;

  // Bit lasts corrLen plus the clock spent at zero
  assign corrLen = baud[15:3] - bitLen_t'(!longShort[0]);
  assign cntNext = start ? bitCount : bitCnt - bitCnt_t'(1);

  always_ff @(posedge clkH) begin
    if (rst || cancel) begin
      lenCount <= '0;
      bitCnt <= '0;
    end else if (step) begin
      bitCnt <= cntNext;
      // In receive mode the final bit stops at its middle
      if (halfLastBit && (cntNext == '0)) begin
        lenCount <= corrLen >> 1;
      end else begin
        lenCount <= corrLen;
      end
    end else if (lenCount != '0) begin
      lenCount <= lenCount - bitLen_t'(1);
    end
  end

  // Rotates across back-to-back symbols, restarts once the timer is idle
  always_ff @(posedge clkH) begin
    if (rst) begin
      longShort <= pattern;
    end else if (step) begin
      longShort <= {longShort[0], longShort[7:1]};
    end else if (!busy) begin
      longShort <= pattern;
    end
  end

endmodule

//--- source/frameSequencer.sv
`timescale 1ns/1ps

module frameSequencer (
  input logic clkH,
  input logic rst,
  input linPkg::cmdWord_t head,
  input logic notEmpty,
  output logic pop,
  input logic stopBits2,
  input logic busy,
  input logic lastStop,
  output logic load,
  output linPkg::symbol_t symbol,
  output linPkg::bitCnt_t bitCount
);

  import linPkg::*;

  typedef enum logic [3:0] {
    SeqIdle = 4'b0001,
    SeqBreak = 4'b0010,
    SeqSync = 4'b0100,
    SeqPid = 4'b1000
  } seqState_t;

  seqState_t state;
  seqState_t nextState;
  logic [5:0] pid;
  logic [7:0] pidByte;
  bitCnt_t stopCount;
  bitCnt_t frameCount;
  bitCnt_t breakCount;
  symbol_t breakSymbol;
  logic pidDone;

  // Protected identifier, P1 in bit 7 and P0 in bit 6
  assign pidByte = {~(pid[1] ^ pid[3] ^ pid[4] ^ pid[5]), pid[0] ^ pid[1] ^ pid[2] ^ pid[4], pid};

  // The last stop bit trails the final count, so a second one adds one count
  assign stopCount = bitCnt_t'(stopBits2);
  assign frameCount = bitCnt_t'(FrameBits) + stopCount;
  assign breakCount = bitCnt_t'(BreakBits) + stopCount;
  assign breakSymbol = ~symbol_t'((1 << BreakBits) - 1);

  // With two stop bits the header is released during the second one
  assign pidDone = stopBits2 ? lastStop : !busy;

  always_comb begin
    nextState = state;
    load = 1'b0;
    pop = 1'b0;
    symbol = '1;
    bitCount = '0;
    case (state)
      SeqIdle: begin
        if (notEmpty && !busy) begin
          load = 1'b1;
          pop = 1'b1;
          if (head[8]) begin
            symbol = breakSymbol;
            bitCount = breakCount;
            nextState = SeqBreak;
          end else begin
            symbol = {7'h7F, head[7:0], 1'b0};
            bitCount = frameCount;
          end
        end
      end
      SeqBreak: begin
        if (!busy) begin
          load = 1'b1;
          symbol = {7'h7F, SyncByte, 1'b0};
          bitCount = frameCount;
          nextState = SeqSync;
        end
      end
      SeqSync: begin
        if (!busy) begin
          load = 1'b1;
          symbol = {7'h7F, pidByte, 1'b0};
          bitCount = frameCount;
          nextState = SeqPid;
        end
      end
      SeqPid: begin
        if (pidDone) begin
          nextState = SeqIdle;
        end
      end
      default: nextState = SeqIdle;
    endcase
  end

  always_ff @(posedge clkH) begin
    if (rst) begin
      state <= SeqIdle;
    end else begin
      state <= nextState;
    end
  end

  // Identifier is kept until the sync field is out
  always_ff @(posedge clkH) begin
    if (pop && head[8]) begin
      pid <= head[5:0];
    end
  end

endmodule

//--- source/uartTransmitter.sv
`timescale 1ns/1ps

module uartTransmitter (
  input logic clkH,
  input logic rst,
  input linPkg::baud_t baud,
  input logic load,
  input linPkg::symbol_t symbol,
  input linPkg::bitCnt_t bitCount,
  output logic tx,
  output logic busy,
  output logic lastStop
);

  import linPkg::*;

  symbol_t shiftReg;
  bitCnt_t bitsLeft;
  logic nextBit;
  logic dualStop;

  bitTimer #(.halfLastBit(1'b0)) i_bitTimer (
    .clkH(clkH), .rst(rst), .baud(baud),
    .start(load), .bitCount(bitCount), .cancel(1'b0),
    .nextBit(nextBit), .bitsLeft(bitsLeft), .busy(busy)
  );

  // Line idles high, ones shift in from the top
  always_ff @(posedge clkH) begin
    if (rst) begin
      shiftReg <= '1;
    end else if (load) begin
      shiftReg <= symbol;
    end else if (nextBit) begin
      shiftReg <= {1'b1, shiftReg[15:1]};
    end else if (!busy) begin
      shiftReg <= '1;
    end
  end

  // One count above a plain byte or break means a second stop bit
  always_ff @(posedge clkH) begin
    if (rst) begin
      dualStop <= 1'b0;
    end else if (load) begin
      dualStop <= (bitCount == bitCnt_t'(FrameBits + 1)) ||
                  (bitCount == bitCnt_t'(BreakBits + 1));
    end
  end

  assign tx = shiftReg[0];
  assign lastStop = busy && (bitsLeft == '0) && dualStop;

endmodule

//--- source/uartReceiver.sv
`timescale 1ns/1ps

module uartReceiver (
  input logic clkH,
  input logic rst,
  input linPkg::baud_t baud,
  input logic rx,
  output logic push,
  output linPkg::rxWord_t rxWord
);

  import linPkg::*;

  typedef enum logic [1:0] {
    RxArmed,
    RxStartHalf,
    RxData,
    RxWaitHigh
  } rxState_t;

  rxState_t state;
  logic [2:0] rxPipe;
  logic line;
  logic fall;
  logic timerStart;
  logic nextBit;
  logic busy;
  logic stopSample;
  bitCnt_t bitsLeft;
  bitCnt_t runBits;
  logic [7:0] dataReg;

  // Two synchronizer stages, the third holds the previous level
  assign line = rxPipe[1];
  assign fall = rxPipe[2] & ~rxPipe[1];

  // Half a start bit first, then one full bit per sample
  assign runBits = (state == RxArmed) ? '0 : bitCnt_t'(FrameBits);
  assign timerStart = ((state == RxArmed) && fall) ||
                      ((state == RxStartHalf) && !busy && !line);
  assign stopSample = (state == RxData) && nextBit && (bitsLeft == bitCnt_t'(1));

  bitTimer #(.halfLastBit(1'b1)) i_bitTimer (
    .clkH(clkH), .rst(rst), .baud(baud),
    .start(timerStart), .bitCount(runBits), .cancel(stopSample),
    .nextBit(nextBit), .bitsLeft(bitsLeft), .busy(busy)
  );

  always_ff @(posedge clkH) begin
    if (rst) begin
      state <= RxArmed;
      rxPipe <= '1;
      push <= 1'b0;
    end else begin
      rxPipe <= {rxPipe[1:0], rx};
      push <= stopSample;
      case (state)
        RxArmed: if (fall) state <= RxStartHalf;
        // A start bit gone high at its middle was a glitch
        RxStartHalf: if (!busy) state <= line ? RxArmed : RxData;
        RxData: if (stopSample) state <= line ? RxArmed : RxWaitHigh;
        RxWaitHigh: if (line) state <= RxArmed;
        default: state <= RxArmed;
      endcase
    end
  end

  // Data comes LSB first, a low stop bit sets the error flag
  always_ff @(posedge clkH) begin
    if ((state == RxData) && nextBit && !stopSample) begin
      dataReg <= {line, dataReg[7:1]};
    end
    if (stopSample) begin
      rxWord <= {~line, dataReg};
    end
  end

endmodule

//--- source/linMaster.sv
`timescale 1ns/1ps

module linMaster (
  input logic clkH,
  input logic rst,
  input linPkg::baud_t baud,
  input logic stopBits2,
  input logic cmdValid,
  input linPkg::cmdWord_t cmdData,
  output logic cmdCredit,
  input logic rxCredit,
  output logic rxValid,
  output linPkg::rxWord_t rxData,
  output logic rxOverflow,
  output logic tx,
  input logic rx
);

  import linPkg::*;

  cmdWord_t cmdHead;
  logic cmdNotEmpty;
  logic cmdPop;
  logic txLoad;
  symbol_t txSymbol;
  bitCnt_t txBitCount;
  logic txBusy;
  logic txLastStop;
  logic rxPush;
  rxWord_t rxWord;
  rxWord_t rxHead;
  logic rxNotEmpty;
  logic rxNotFull;
  logic rxPop;
  logic [CreditWidth-1:0] rxCredits;

  // Host credits keep this FIFO from filling
  creditFifo #(.payload_t(cmdWord_t), .depth(CmdFifoDepth)) i_cmdFifo (
    .clkH(clkH), .rst(rst),
    .push(cmdValid), .pushData(cmdData), .pop(cmdPop),
    .head(cmdHead), .notEmpty(cmdNotEmpty), .notFull()
  );

  frameSequencer i_frameSequencer (
    .clkH(clkH), .rst(rst),
    .head(cmdHead), .notEmpty(cmdNotEmpty), .pop(cmdPop), .stopBits2(stopBits2),
    .busy(txBusy), .lastStop(txLastStop),
    .load(txLoad), .symbol(txSymbol), .bitCount(txBitCount)
  );

  uartTransmitter i_uartTransmitter (
    .clkH(clkH), .rst(rst), .baud(baud),
    .load(txLoad), .symbol(txSymbol), .bitCount(txBitCount),
    .tx(tx), .busy(txBusy), .lastStop(txLastStop)
  );

  uartReceiver i_uartReceiver (
    .clkH(clkH), .rst(rst), .baud(baud),
    .rx(rx), .push(rxPush), .rxWord(rxWord)
  );

  creditFifo #(.payload_t(rxWord_t), .depth(RxFifoDepth)) i_rxFifo (
    .clkH(clkH), .rst(rst),
    .push(rxPush), .pushData(rxWord), .pop(rxPop),
    .head(rxHead), .notEmpty(rxNotEmpty), .notFull(rxNotFull)
  );

  // One word per granted credit
  assign rxPop = (rxCredits != '0) && rxNotEmpty;

  always_ff @(posedge clkH) begin
    if (rst) begin
      cmdCredit <= 1'b0;
      rxValid <= 1'b0;
      rxOverflow <= 1'b0;
      rxCredits <= '0;
    end else begin
      cmdCredit <= cmdPop;
      rxValid <= rxPop;
      // Sticky until reset
      if (rxPush && !rxNotFull) begin
        rxOverflow <= 1'b1;
      end
      if (rxCredit && !rxPop) begin
        rxCredits <= rxCredits + CreditWidth'(1);
      end else if (rxPop && !rxCredit) begin
        rxCredits <= rxCredits - CreditWidth'(1);
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (rxPop) begin
      rxData <= rxHead;
    end
  end

endmodule

//--- sim/linMasterTb.sv
`timescale 1ns/1ps

module linMasterTb;

  import linPkg::*;

  typedef struct packed {
    baud_t baud;
    logic stop2;
    logic hdr;
    logic [5:0] id;
    logic [3:0] nData;
    logic withhold;
    logic forceStop;
  } testRow_t;

  localparam int NumTests = 7;

  logic clkH;
  logic rst;
  baud_t baud;
  logic stopBits2;
  logic cmdValid;
  cmdWord_t cmdData;
  logic cmdCredit;
  logic rxCredit;
  logic rxValid;
  rxWord_t rxData;
  logic rxOverflow;
  logic tx;
  logic rx;
  logic forceLow;

  testRow_t tests [NumTests];
  logic [31:0] lfsr;
  int errors;
  int testsFailed;
  logic timedOut;

  // Loopback with an override that pulls the line low
  assign rx = tx & ~forceLow;

  linMaster i_linMaster (
    .clkH(clkH), .rst(rst), .baud(baud), .stopBits2(stopBits2),
    .cmdValid(cmdValid), .cmdData(cmdData), .cmdCredit(cmdCredit),
    .rxCredit(rxCredit), .rxValid(rxValid), .rxData(rxData), .rxOverflow(rxOverflow),
    .tx(tx), .rx(rx)
  );

  always #20 clkH = ~clkH;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  task automatic drawByte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
  endtask

  // P1 in bit 7, P0 in bit 6
  function automatic logic [7:0] protectedId(input logic [5:0] id);
    logic p0;
    logic p1;
    p0 = id[0] ^ id[1] ^ id[2] ^ id[4];
    p1 = ~(id[1] ^ id[3] ^ id[4] ^ id[5]);
    return {p1, p0, id};
  endfunction

  task automatic flagMismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic runTest(input int num, input testRow_t row, output logic timeout);
    cmdWord_t cmds[$];
    rxWord_t expWords[$];
    logic [7:0] b;
    int bitLen;
    int symbols;
    int frameBits;
    int limit;
    int cyc;
    int cmdIdx;
    int hostCredits;
    int returned;
    int granted;
    int got;
    int idle;
    int fallCycle;
    int syncStart;
    int syncFalls;
    int phase;
    int errorsBefore;
    logic prevTx;
    logic released;
    logic expOverflow;
    logic done;

    errorsBefore = errors;
    timeout = 1'b0;
    // Break reads as a zero byte with a low stop bit
    if (row.hdr) begin
      cmds.push_back({1'b1, 2'b00, row.id});
      expWords.push_back({1'b1, 8'h00});
      expWords.push_back({1'b0, SyncByte});
      expWords.push_back({1'b0, protectedId(row.id)});
    end
    for (int i = 0; i < int'(row.nData); i++) begin
      drawByte(b);
      cmds.push_back({1'b0, b});
      expWords.push_back({row.forceStop && (i == int'(row.nData) - 1), b});
    end
    expOverflow = row.withhold && (expWords.size() > RxFifoDepth);
    // Only what fits in the receive FIFO survives
    if (row.withhold) begin
      while (expWords.size() > RxFifoDepth) begin
        void'(expWords.pop_back());
      end
    end

    bitLen = int'(row.baud[15:3]);
    symbols = (row.hdr ? 3 : 0) + int'(row.nData);
    frameBits = (row.hdr ? (BreakBits + 1) + 2 * (FrameBits + 1) : 0) +
                int'(row.nData) * (FrameBits + 1) + (row.stop2 ? symbols : 0);
    limit = (frameBits + 4) * bitLen * 2;

    @(negedge clkH);
    rst = 1'b1;
    baud = row.baud;
    stopBits2 = row.stop2;
    cmdValid = 1'b0;
    rxCredit = 1'b0;
    forceLow = 1'b0;
    repeat (8) @(negedge clkH);
    rst = 1'b0;
    @(negedge clkH);
    if (tx !== 1'b1 || cmdCredit !== 1'b0 || rxValid !== 1'b0 || rxOverflow !== 1'b0) begin
      flagMismatch("outputs not idle after reset");
    end

    cyc = 0;
    cmdIdx = 0;
    hostCredits = CmdFifoDepth;
    returned = 0;
    granted = 0;
    got = 0;
    idle = 0;
    fallCycle = -1;
    syncStart = 0;
    syncFalls = 0;
    phase = 0;
    prevTx = 1'b1;
    released = !row.withhold;
    done = 1'b0;

    while (!done && !timeout) begin
      if (cmdCredit) begin
        returned++;
        hostCredits++;
        if (returned > cmdIdx) begin
          flagMismatch("cmdCredit pulse without a pending command");
        end
      end
      if (rxValid) begin
        if (!released) begin
          flagMismatch("rxValid while rx credits are withheld");
        end
        if (got >= expWords.size()) begin
          flagMismatch($sformatf("extra word %03h", rxData));
        end else if (rxData !== expWords[got]) begin
          flagMismatch($sformatf("word %0d is %03h, expected %03h", got, rxData, expWords[got]));
        end
        got++;
      end

      // Break fall, break stop rise, then sync start to the fall of d7
      if (row.hdr) begin
        if (phase == 0 && prevTx && !tx) begin
          phase = 1;
        end else if (phase == 1 && !prevTx && tx) begin
          phase = 2;
        end else if (phase == 2 && prevTx && !tx) begin
          syncStart = cyc;
          phase = 3;
        end else if (phase == 3 && prevTx && !tx) begin
          syncFalls++;
          if (syncFalls == 4) begin
            if (cyc - syncStart != int'(row.baud)) begin
              flagMismatch($sformatf("eight sync bits took %0d clocks, expected %0d",
                                     cyc - syncStart, row.baud));
            end
            phase = 4;
          end
        end
      end

      if (tx && !forceLow) begin
        idle++;
      end else begin
        idle = 0;
      end

      // Hold the line low across the stop bit of the byte
      if (row.forceStop && fallCycle < 0 && prevTx && !tx) begin
        fallCycle = cyc;
      end
      forceLow = (fallCycle >= 0) && (cyc - fallCycle >= 9 * bitLen + bitLen / 4) &&
                 (cyc - fallCycle < 10 * bitLen - bitLen / 4);

      cmdValid = 1'b0;
      if (cmdIdx < cmds.size() && hostCredits > 0) begin
        cmdValid = 1'b1;
        cmdData = cmds[cmdIdx];
        cmdIdx++;
        hostCredits--;
      end

      // A byte with two stop bits stays high for ten bit times at most
      if (!released && cmdIdx == cmds.size() && idle >= (FrameBits + 2) * bitLen) begin
        released = 1'b1;
      end
      rxCredit = released && (granted - got < 2);
      if (rxCredit) begin
        granted++;
      end

      if (cmdIdx == cmds.size() && released && idle >= (FrameBits + 3) * bitLen) begin
        done = 1'b1;
      end
      prevTx = tx;
      cyc++;
      if (cyc > limit) begin
        $display("Test %0d timed out after %0d cycles", num, cyc);
        timeout = 1'b1;
      end
      @(negedge clkH);
    end
    cmdValid = 1'b0;
    rxCredit = 1'b0;
    forceLow = 1'b0;

    if (!timeout) begin
      if (got != expWords.size()) begin
        flagMismatch($sformatf("received %0d words, expected %0d", got, expWords.size()));
      end
      if (returned != cmds.size()) begin
        flagMismatch($sformatf("%0d cmdCredit pulses for %0d commands", returned, cmds.size()));
      end
      if (rxOverflow !== expOverflow) begin
        flagMismatch($sformatf("rxOverflow is %b, expected %b", rxOverflow, expOverflow));
      end
      if (row.hdr && phase != 4) begin
        flagMismatch("sync field never seen on tx");
      end
    end
    if (timeout || errors != errorsBefore) begin
      testsFailed++;
      $display("Test %0d baud %0d stop bits %0d: FAIL", num, row.baud, row.stop2 + 1);
    end else begin
      $display("Test %0d baud %0d stop bits %0d: ok", num, row.baud, row.stop2 + 1);
    end
  endtask

  initial begin
    clkH = 1'b0;
    rst = 1'b1;
    baud = 16'd800;
    stopBits2 = 1'b0;
    cmdValid = 1'b0;
    cmdData = '0;
    rxCredit = 1'b0;
    forceLow = 1'b0;
    lfsr = 32'h9904eab7;
    errors = 0;
    testsFailed = 0;
    timedOut = 1'b0;

    // baud, stop2, header, id, data bytes, withhold rx credits, force stop low
    tests[0] = '{16'd800, 1'b0, 1'b1, 6'h3C, 4'd0, 1'b0, 1'b0};
    tests[1] = '{16'd800, 1'b0, 1'b1, 6'h15, 4'd5, 1'b0, 1'b0};
    tests[2] = '{16'd800, 1'b1, 1'b1, 6'h2A, 4'd4, 1'b0, 1'b0};
    tests[3] = '{16'd803, 1'b0, 1'b1, 6'h07, 4'd4, 1'b0, 1'b0};
    tests[4] = '{16'd803, 1'b1, 1'b1, 6'h31, 4'd2, 1'b0, 1'b0};
    tests[5] = '{16'd800, 1'b0, 1'b1, 6'h12, 4'd3, 1'b1, 1'b0};
    tests[6] = '{16'd800, 1'b0, 1'b0, 6'h00, 4'd1, 1'b0, 1'b1};

    for (int t = 0; t < NumTests && !timedOut; t++) begin
      runTest(t, tests[t], timedOut);
    end

    $display("%0d tests, %0d failed, %0d errors", NumTests, testsFailed, errors);
    if (errors == 0 && testsFailed == 0 && !timedOut) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sim.f
source/linPkg.sv
source/creditFifo.sv
source/bitTimer.sv
source/frameSequencer.sv
source/uartTransmitter.sv
source/uartReceiver.sv
source/linMaster.sv
sim/linMasterTb.sv

//--- Makefile
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= linMasterTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG = Some tests failed
PASS_MSG = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
